/* Bender.yml */
package:
  name: tanh_stream

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/tanh_pkg.sv
      - verilog/fixed_round.sv
      - verilog/tanh_lane.sv
      - verilog/tanh_array.sv
      - verilog/tensor_framer.sv
      - verilog/tanh_stream_top.sv

  - target: test
    include_dirs:
      - verilog
      - verification
    files:
      - verification/tb_tanh_stream_top.sv

dependencies: {}

frozen: false

/* sim.f */
+incdir+verilog
+incdir+verification
verilog/tanh_pkg.sv
verilog/fixed_round.sv
verilog/tanh_lane.sv
verilog/tanh_array.sv
verilog/tensor_framer.sv
verilog/tanh_stream_top.sv
verification/tb_tanh_stream_top.sv

/* verification/tanh_model.svh */
`ifndef TANH_MODEL_SVH
`define TANH_MODEL_SVH

`include "tanh_params.svh"

// reference tanh for one Q8.8 sample, built from the two-segment rule
function automatic logic signed [`TANH_W-1:0] tanh_model(
  input logic signed [`TANH_W-1:0] x
);
  longint mag;
  longint sq;
  longint acc;
  longint q;
  int     acc_frac;
  int     drop;
  mag      = x;                                       // sign extended
  acc_frac = 2 * `TANH_FRAC + `TANH_CONST_FRAC;
  drop     = acc_frac - `TANH_FRAC;
  if (mag < 0) begin
    mag = -mag;
  end
  sq = mag * mag;                                     // 2*FRAC fraction bits
  if (mag <= longint'(`TANH_A)) begin
    acc = longint'(`TANH_M1) * sq
        + (mag <<< (acc_frac - `TANH_FRAC))
        + (longint'(`TANH_D1) <<< (acc_frac - `TANH_CONST_FRAC));
  end else if (mag <= longint'(`TANH_B)) begin
    acc = longint'(`TANH_M2) * sq
        + ((longint'(`TANH_C2) * mag) <<< (acc_frac - `TANH_FRAC - `TANH_CONST_FRAC))
        + (longint'(`TANH_D2) <<< (acc_frac - `TANH_CONST_FRAC));
  end else begin
    acc = longint'(1) <<< acc_frac;                   // flat at 1.0
  end
  q = (acc + (longint'(1) <<< (drop - 1))) >>> drop;  // nearest, ties up
  if (q > 32767) begin
    q = 32767;
  end else if (q < -32768) begin
    q = -32768;
  end
  if (x < 0) begin
    q = -q;                                           // odd function
  end
  return q[`TANH_W-1:0];
endfunction

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

`endif

/* verification/tb_tanh_stream_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tanh_params.svh"

module tb_tanh_stream_top;

  import tanh_pkg::*;

  `include "tanh_model.svh"

  localparam int CLK_PERIOD       = 10;
  localparam int RESET_CYCLES     = 16;
  localparam int TABLE_LEN        = 64;
  localparam int NUM_BEATS        = TABLE_LEN / `TANH_PAR;
  localparam int NUM_FIXED        = 17;                  // landmark rows
  localparam int BEATS_PER_TENSOR = `TANH_TENSOR_LEN / `TANH_PAR;
  localparam int PRE_RESET_BEATS  = 5;                   // cut off by the second reset
  localparam int POST_RESET_BEATS = 10;
  localparam int TOTAL_BEATS      = 2 * NUM_BEATS + PRE_RESET_BEATS + POST_RESET_BEATS;
  localparam int WATCHDOG_CYCLES  = TOTAL_BEATS * 20 + 200 + 2 * RESET_CYCLES;

  logic         clk = 1'b0;
  logic         rst;
  beat_t        in_beat;
  logic         in_valid;
  logic         in_ready;
  tagged_beat_t out_beat;
  logic         out_valid;
  logic         out_ready;

  logic signed [`TANH_W-1:0] stim_x [TABLE_LEN];
  logic signed [`TANH_W-1:0] stim_y [TABLE_LEN];

  logic [31:0]  lfsr_state;
  beat_t        cur_expect;                              // expected lanes of in_beat
  tagged_beat_t exp_q [$];
  int           exp_adv_q [$];
  int           errors        = 0;
  int           beats_sent    = 0;
  int           beats_out     = 0;
  int           beats_checked = 0;
  int           adv_cnt       = 0;
  int           tensor_pos    = 0;
  bit           prev_rst      = 1'b0;
  bit           prev_stalled  = 1'b0;
  logic         prev_valid;
  tagged_beat_t prev_beat;

  tanh_stream_top DUT (
    .clk      (clk),
    .rst      (rst),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .out_ready(out_ready),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic random_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], random_bit()};
    end
    return bits;
  endfunction

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] want);
    if (got !== want) begin
      $display("Fail %s: got 0x%0h, expected 0x%0h at %0t", name, got, want, $time);
      errors++;
    end
  endtask

  // landmark rows come first and random rows follow them
  function automatic void fill_table();
    logic [31:0] bits;
    stim_x[0]  = '0;
    stim_x[1]  = `TANH_A;
    stim_x[2]  = -`TANH_A;
    stim_x[3]  = `TANH_A + 16'sd1;
    stim_x[4]  = `TANH_A - 16'sd1;
    stim_x[5]  = -(`TANH_A + 16'sd1);
    stim_x[6]  = -(`TANH_A - 16'sd1);
    stim_x[7]  = `TANH_B;
    stim_x[8]  = -`TANH_B;
    stim_x[9]  = `TANH_B + 16'sd1;
    stim_x[10] = `TANH_B - 16'sd1;
    stim_x[11] = -(`TANH_B + 16'sd1);
    stim_x[12] = -(`TANH_B - 16'sd1);
    stim_x[13] = 16'sh0800;                              // 8.0
    stim_x[14] = -16'sh0800;
    stim_x[15] = 16'sh7FFF;
    stim_x[16] = 16'sh8000;
    for (int i = NUM_FIXED; i < TABLE_LEN; i++) begin
      if (random_bit()) begin
        bits      = random_bits(16);                     // whole range
        stim_x[i] = bits[15:0];
      end else begin
        bits      = random_bits(11);                     // within +-4.0
        stim_x[i] = {{5{bits[10]}}, bits[10:0]};
      end
    end
    for (int i = 0; i < TABLE_LEN; i++) begin
      stim_y[i] = tanh_model(stim_x[i]);
    end
  endfunction

  task automatic apply_reset();
    rst      <= 1'b1;
    in_valid <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    beats_sent = 0;
  endtask

  // sends table beats first .. first+count-1 with wrap around the table
  task automatic run_beats(input int first, input int count, input bit stalls,
                           input bit gaps);
    int    idx;
    bit    pending;
    beat_t beat;
    beat_t want_beat;
    idx     = first;
    pending = 1'b0;
    while (idx < first + count) begin
      if (!pending) begin
        if (gaps && !random_bit()) begin
          in_valid <= 1'b0;                              // idle cycle
        end else begin
          for (int l = 0; l < `TANH_PAR; l++) begin
            beat.lanes[l]      = stim_x[(idx % NUM_BEATS) * `TANH_PAR + l];
            want_beat.lanes[l] = stim_y[(idx % NUM_BEATS) * `TANH_PAR + l];
          end
          in_beat    <= beat;
          cur_expect <= want_beat;
          in_valid   <= 1'b1;
          pending = 1'b1;
        end
      end
      out_ready <= stalls ? random_bit() : 1'b1;
      @(posedge clk);
      if (pending && in_ready) begin                     // held until accepted
        pending = 1'b0;
        idx++;
        beats_sent++;
      end
    end
    in_valid <= 1'b0;
  endtask

  task automatic drain(input bit stalls);
    while (beats_out != beats_sent) begin
      out_ready <= stalls ? random_bit() : 1'b1;
      @(posedge clk);
    end
    out_ready <= 1'b1;
  endtask

  // scoreboard and protocol monitor on the values from before the edge
  always @(posedge clk) begin
    tagged_beat_t want;
    int           hs_adv;
    if (prev_rst) begin
      check_value("out_valid", out_valid, 1'b0);
      check_value("out_beat.last", out_beat.last, 1'b0);
    end
    if (rst) begin
      exp_q.delete();
      exp_adv_q.delete();
      tensor_pos = 0;
      beats_out <= 0;
    end else begin
      check_value("in_ready", in_ready, out_ready);
      if (prev_stalled) begin
        check_value("out_valid", out_valid, prev_valid);
        check_value("out_beat", out_beat, prev_beat);
      end
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error: output beat arrived with no beat outstanding at %0t", $time);
          errors++;
        end else begin
          want   = exp_q.pop_front();
          hs_adv = exp_adv_q.pop_front();
          for (int l = 0; l < `TANH_PAR; l++) begin
            check_value($sformatf("out_beat.data.lanes[%0d]", l),
                        $unsigned(out_beat.data.lanes[l]), $unsigned(want.data.lanes[l]));
          end
          check_value("out_beat.last", out_beat.last, want.last);
          check_value("out_valid latency", adv_cnt - hs_adv, 3);
          beats_checked++;
        end
        beats_out <= beats_out + 1;
      end
      if (in_valid && in_ready) begin
        want.data = cur_expect;
        want.last = (tensor_pos == BEATS_PER_TENSOR - 1);
        exp_q.push_back(want);
        exp_adv_q.push_back(adv_cnt);
        tensor_pos = want.last ? 0 : tensor_pos + 1;
      end
      if (out_ready) begin
        adv_cnt++;                                       // pipeline moved
      end
    end
    prev_rst     = rst;
    prev_stalled = !rst && !out_ready;
    prev_valid   = out_valid;
    prev_beat    = out_beat;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the run timed out with %0d beats still outstanding",
             beats_sent - beats_out);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    lfsr_state = 32'habbb4ecd;
    rst        <= 1'b1;
    in_valid   <= 1'b0;
    in_beat    <= '0;
    out_ready  <= 1'b0;
    cur_expect <= '0;
    fill_table();
    apply_reset();
    run_beats(0, NUM_BEATS, 1'b0, 1'b0);                 // full rate without stalls
    drain(1'b0);
    run_beats(0, NUM_BEATS, 1'b1, 1'b1);                 // random stalls and gaps
    drain(1'b1);
    run_beats(0, PRE_RESET_BEATS, 1'b0, 1'b0);
    apply_reset();                                       // beats still in flight
    run_beats(PRE_RESET_BEATS, POST_RESET_BEATS, 1'b1, 1'b1);
    drain(1'b1);
    $display("errors: %0d, beats checked: %0d", errors, beats_checked);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/fixed_round.sv */
`timescale 1ns/100ps
`default_nettype none

module fixed_round #(
  parameter int IN_W     = 49,
  parameter int IN_FRAC  = 32,
  parameter int OUT_W    = 16,
  parameter int OUT_FRAC = 8
) (
  input  logic signed [IN_W-1:0]  data_in,
  output logic signed [OUT_W-1:0] data_out
);

  localparam int DROP    = IN_FRAC - OUT_FRAC;  // surplus fraction bits
  localparam int SUM_W   = IN_W + 1;            // room for the rounding carry
  localparam int TRUNC_W = SUM_W - DROP;

  localparam logic [SUM_W-1:0] HALF_LSB = SUM_W'(1) << (DROP - 1);  // half an output lsb

  localparam logic signed [OUT_W-1:0] OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
  localparam logic signed [OUT_W-1:0] OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};

  logic signed [SUM_W-1:0]   sum;
  logic signed [TRUNC_W-1:0] trunc;
  logic [TRUNC_W-OUT_W:0]    top_bits;
  logic                      overflow;

  assign sum      = {data_in[IN_W-1], data_in} + HALF_LSB;   // ties go up
  assign trunc    = sum[SUM_W-1:DROP];

  // Every bit above the output sign must match it, or the value does not fit.
  assign top_bits = trunc[TRUNC_W-1:OUT_W-1];
  assign overflow = ~((&top_bits) | ~(|top_bits));

  assign data_out = overflow ? (trunc[TRUNC_W-1] ? OUT_MIN : OUT_MAX)
                             : trunc[OUT_W-1:0];

endmodule

`default_nettype wire

/* verilog/tanh_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tanh_params.svh"

module tanh_array (
  input  logic                   clk,
  input  logic                   rst,
  input  tanh_pkg::beat_t        in_beat,
  input  logic                   in_valid,
  input  logic                   in_last,
  input  logic                   out_ready,
  output logic                   in_ready,
  output tanh_pkg::tagged_beat_t out_beat,
  output logic                   out_valid
);

  import tanh_pkg::*;

  localparam int DEPTH = 3;  // matches the lane pipeline

  logic             adv;
  logic [DEPTH-1:0] valid_sr;
  logic [DEPTH-1:0] last_sr;
  sample_t          lane_y [`TANH_PAR];

  // no buffering, so the whole pipe moves only when the sink takes data
  assign adv      = out_ready;
  assign in_ready = adv;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_sr <= '0;
      last_sr  <= '0;
    end else if (adv) begin
      valid_sr <= {valid_sr[DEPTH-2:0], in_valid};
      last_sr  <= {last_sr[DEPTH-2:0], in_valid & in_last};  // tag only real beats
    end
  end

  for (genvar i = 0; i < `TANH_PAR; i++) begin : g_lane
    tanh_lane u_lane (
      .clk(clk),
      .rst(rst),
      .adv(adv),
      .x  (in_beat.lanes[i]),
      .y  (lane_y[i])
    );
  end

  always_comb begin
    for (int i = 0; i < `TANH_PAR; i++) begin
      out_beat.data.lanes[i] = lane_y[i];
    end
    out_beat.last = last_sr[DEPTH-1];
  end

  assign out_valid = valid_sr[DEPTH-1];

endmodule

`default_nettype wire

/* verilog/tanh_lane.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tanh_params.svh"

module tanh_lane (
  input  logic              clk,
  input  logic              rst,
  input  logic              adv,
  input  tanh_pkg::sample_t x,
  output tanh_pkg::sample_t y
);

  import tanh_pkg::*;

  localparam int ABS_W    = `TANH_W;
  localparam int SQ_W     = 2 * `TANH_W;
  localparam int COEF_W   = `TANH_CONST_FRAC + 1;
  localparam int RES_FRAC = 2 * `TANH_FRAC + `TANH_CONST_FRAC;  // Q.32 accumulator
  localparam int RES_W    = 2 * `TANH_W + COEF_W;

  localparam logic [1:0] SEG_INNER = 2'd0;  // |x| <= A
  localparam logic [1:0] SEG_OUTER = 2'd1;  // A < |x| <= B
  localparam logic [1:0] SEG_SAT   = 2'd2;  // |x| > B

  localparam logic signed [RES_W-1:0] ONE = RES_W'(1) << RES_FRAC;

  logic [ABS_W-1:0]          x_abs;
  logic [1:0]                seg;
  logic signed [RES_W-1:0]   lin_term;
  logic signed [RES_W-1:0]   const_term;
  logic signed [COEF_W-1:0]  quad_coef;
  logic signed [RES_W-1:0]   quad_sum;
  sample_t                   rounded;

  logic [ABS_W-1:0]          s1_abs;
  logic [SQ_W-1:0]           s1_sq;
  logic                      s1_neg;
  logic [1:0]                s1_seg;

  logic [SQ_W-1:0]           s2_sq;
  logic                      s2_neg;
  logic [1:0]                s2_seg;
  logic signed [RES_W-1:0]   s2_lin;
  logic signed [RES_W-1:0]   s2_const;

  logic signed [RES_W-1:0]   s3_sum;
  logic                      s3_neg;

  // magnitude is unsigned so the most negative input still fits
  assign x_abs = x[`TANH_W-1] ? $unsigned(-x) : $unsigned(x);

  always_comb begin
    if (x_abs <= $unsigned(`TANH_A)) begin
      seg = SEG_INNER;
    end else if (x_abs <= $unsigned(`TANH_B)) begin
      seg = SEG_OUTER;
    end else begin
      seg = SEG_SAT;
    end
  end

  // linear and constant terms, aligned to the accumulator format
  always_comb begin
    case (s1_seg)
      SEG_INNER: begin
        lin_term   = RES_W'(s1_abs) << (RES_FRAC - `TANH_FRAC);  // slope of one
        const_term = RES_W'(`TANH_D1) <<< (RES_FRAC - `TANH_CONST_FRAC);
      end
      SEG_OUTER: begin
        lin_term   = ($signed(`TANH_C2) * $signed({1'b0, s1_abs}))
                     <<< (RES_FRAC - `TANH_FRAC - `TANH_CONST_FRAC);
        const_term = RES_W'(`TANH_D2) <<< (RES_FRAC - `TANH_CONST_FRAC);
      end
      default: begin
        lin_term   = '0;
        const_term = '0;
      end
    endcase
  end

  assign quad_coef = (s2_seg == SEG_INNER) ? `TANH_M1 : `TANH_M2;
  assign quad_sum  = quad_coef * $signed({1'b0, s2_sq}) + s2_lin + s2_const;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_abs   <= '0;
      s1_sq    <= '0;
      s1_neg   <= 1'b0;
      s1_seg   <= SEG_INNER;
      s2_sq    <= '0;
      s2_neg   <= 1'b0;
      s2_seg   <= SEG_INNER;
      s2_lin   <= '0;
      s2_const <= '0;
      s3_sum   <= '0;
      s3_neg   <= 1'b0;
    end else if (adv) begin
      s1_abs   <= x_abs;
      s1_sq    <= x_abs * x_abs;                          // Q16.16
      s1_neg   <= x[`TANH_W-1];
      s1_seg   <= seg;
      s2_sq    <= s1_sq;
      s2_neg   <= s1_neg;
      s2_seg   <= s1_seg;
      s2_lin   <= lin_term;
      s2_const <= const_term;
      s3_sum   <= (s2_seg == SEG_SAT) ? ONE : quad_sum;   // tanh is flat out here
      s3_neg   <= s2_neg;
    end
  end

  fixed_round #(
    .IN_W    (RES_W),
    .IN_FRAC (RES_FRAC),
    .OUT_W   (`TANH_W),
    .OUT_FRAC(`TANH_FRAC)
  ) u_round (
    .data_in (s3_sum),
    .data_out(rounded)
  );

  assign y = s3_neg ? -rounded : rounded;  // odd symmetry

endmodule

`default_nettype wire

/* verilog/tanh_params.svh */
`ifndef TANH_PARAMS_SVH
`define TANH_PARAMS_SVH

// sample format, Q8.8 on input and output
`define TANH_W            16
`define TANH_FRAC         8

// stream shape
`define TANH_PAR          4      // samples per beat
`define TANH_TENSOR_LEN   32     // samples per tensor, multiple of TANH_PAR
`define TANH_BEAT_CNT_W   3      // holds TANH_TENSOR_LEN / TANH_PAR beats

// polynomial coefficients, signed Q1.16
`define TANH_CONST_FRAC   16
`define TANH_M1           17'sh1BA77   // -0.2716
`define TANH_D1           17'sh00418   //  0.0160
`define TANH_M2           17'sh1EA4C   // -0.0848
`define TANH_C2           17'sh06D31   //  0.4265
`define TANH_D2           17'sh073AF   //  0.4519

// Segment bounds on |x|, already rounded to Q8.8.
// Inner segment up to A, outer segment up to B, constant 1.0 beyond.
`define TANH_A            16'sd389     // 1.52
`define TANH_B            16'sd658     // 2.57

`endif

/* verilog/tanh_pkg.sv */
`default_nettype none

`include "tanh_params.svh"

package tanh_pkg;

  // one signed fixed-point sample
  typedef logic signed [`TANH_W-1:0] sample_t;

  // one beat of the stream
  typedef struct packed {
    sample_t [`TANH_PAR-1:0] lanes;  // lane 0 in the low bits
  } beat_t;

  // beat plus the tensor boundary marker
  typedef struct packed {
    beat_t data;
    logic  last;                     // final beat of a tensor
  } tagged_beat_t;

endpackage

`default_nettype wire

/* verilog/tanh_stream_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tanh_stream_top (
  input  logic                   clk,
  input  logic                   rst,
  input  tanh_pkg::beat_t        in_beat,
  input  logic                   in_valid,
  input  logic                   out_ready,
  output logic                   in_ready,
  output tanh_pkg::tagged_beat_t out_beat,
  output logic                   out_valid
);

  logic in_last;  // framer to array

  // tensor boundary tracking on the input side
  tensor_framer u_framer (
    .clk     (clk),
    .rst     (rst),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .in_last (in_last)
  );

  tanh_array u_array (
    .clk      (clk),
    .rst      (rst),
    .in_beat  (in_beat),
    .in_valid (in_valid),
    .in_last  (in_last),
    .out_ready(out_ready),
    .in_ready (in_ready),
    .out_beat (out_beat),
    .out_valid(out_valid)
  );

endmodule

`default_nettype wire

/* verilog/tensor_framer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "tanh_params.svh"

module tensor_framer (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  input  logic in_ready,
  output logic in_last
);

  localparam int BEATS = `TANH_TENSOR_LEN / `TANH_PAR;  // beats per tensor

  localparam logic [`TANH_BEAT_CNT_W-1:0] LAST_CNT = `TANH_BEAT_CNT_W'(BEATS - 1);

  logic [`TANH_BEAT_CNT_W-1:0] beat_cnt;
  logic                        accept;

  assign accept  = in_valid & in_ready;
  assign in_last = (beat_cnt == LAST_CNT);  // straight from the count

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (accept) begin
      if (in_last) begin
        beat_cnt <= '0;                     // next tensor starts
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire
